// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_NOP    = 7'b0000000;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension

    localparam logic [2:0] F3_MUL = 3'b000;
    localparam logic [2:0] F3_DIV = 3'b100;
    localparam logic [2:0] F3_REM = 3'b110;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SRL = 3'b101;  // SRLI and SRAI

    // Station index follows the enum value
    typedef enum logic [1:0] {
        UNIT_ADD = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2,
        UNIT_BR  = 2'd3
    } unit_class_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_word_u;

endpackage

// File: logic/rs_pkg.sv
package rs_pkg;

    localparam int NUM_UNITS = 4;
    localparam int RS_DEPTH  = 4;
    localparam int PHY_W     = 8;
    localparam int CREDIT_W  = 3;  // Holds 0..RS_DEPTH
    localparam int UNIT_W    = $clog2(NUM_UNITS);
    localparam int SLOT_W    = $clog2(RS_DEPTH);

    typedef logic [CREDIT_W-1:0] credit_t;
    typedef logic [UNIT_W-1:0]   unit_idx_t;
    typedef logic [SLOT_W-1:0]   slot_t;

    typedef struct packed {
        rv_isa_pkg::instr_word_u instr;
        logic [31:0]      op1;
        logic [31:0]      op2;
        logic [PHY_W-1:0] op1_phy;
        logic [PHY_W-1:0] op2_phy;
        logic [1:0]       op_valid;  // Bit 0 op1, bit 1 op2
        logic [PHY_W-1:0] rd_phy;
        logic [31:0]      imm;
        logic [31:0]      pc;
        logic [31:0]      inst_num;  // Program order
        logic [3:0]       alu_op;
        logic             mem_to_reg;
        logic             mem_read;
        logic             mem_write;
        logic             alu_src1;
        logic             alu_src2;
        logic             jump;
        logic             branch;
        logic             pred_taken;
        logic             btb_hit;
    } dispatch_pkt_t;

    typedef struct packed {
        logic          busy;
        dispatch_pkt_t pkt;
    } rs_entry_t;

    typedef struct packed {
        logic             valid;
        logic [PHY_W-1:0] tag;
        logic [31:0]      value;
    } cdb_t;

    typedef struct packed {
        logic                    valid;
        rv_isa_pkg::unit_class_t unit;
        dispatch_pkt_t           pkt;
    } issue_pkt_t;

    // Captures a broadcast result into any waiting operand with a matching tag
    function automatic dispatch_pkt_t wakeup(dispatch_pkt_t pkt, cdb_t bus);
        dispatch_pkt_t res;
        res = pkt;
        if (bus.valid && !pkt.op_valid[0] && bus.tag == pkt.op1_phy) begin
            res.op1         = bus.value;
            res.op_valid[0] = 1'b1;
        end
        if (bus.valid && !pkt.op_valid[1] && bus.tag == pkt.op2_phy) begin
            res.op2         = bus.value;
            res.op_valid[1] = 1'b1;
        end
        return res;
    endfunction

endpackage

// File: logic/dispatch_router.sv
module dispatch_router (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dispatch_valid,
    input  rs_pkg::dispatch_pkt_t           dispatch,
    input  logic [rs_pkg::NUM_UNITS-1:0]    credit_return,
    input  rs_pkg::cdb_t                    cdb,
    output logic                            dispatch_ready,
    output logic [rs_pkg::NUM_UNITS-1:0]    wr_en,
    output rs_pkg::rs_entry_t               wr_entry
);

    rv_isa_pkg::unit_class_t unit;
    logic                    is_nop;
    logic                    is_shift_imm;
    logic                    accept;
    rs_pkg::credit_t         credit [rs_pkg::NUM_UNITS];
    rs_pkg::dispatch_pkt_t   pkt;

    // Unit class from the R-type view
    always_comb begin
        unit   = rv_isa_pkg::UNIT_ADD;
        is_nop = 1'b0;
        case (dispatch.instr.r_fields.opcode)
            rv_isa_pkg::OP_NOP: begin
                is_nop = 1'b1;
            end
            rv_isa_pkg::OP_RTYPE: begin
                if (dispatch.instr.r_fields.funct7 == rv_isa_pkg::F7_MULDIV) begin
                    if (dispatch.instr.r_fields.funct3 == rv_isa_pkg::F3_MUL) begin
                        unit = rv_isa_pkg::UNIT_MUL;
                    end else if (dispatch.instr.r_fields.funct3 == rv_isa_pkg::F3_DIV ||
                                 dispatch.instr.r_fields.funct3 == rv_isa_pkg::F3_REM) begin
                        unit = rv_isa_pkg::UNIT_DIV;
                    end
                end
            end
            rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_BRANCH: begin
                unit = rv_isa_pkg::UNIT_BR;
            end
            default: begin
                unit = rv_isa_pkg::UNIT_ADD;
            end
        endcase
    end

    // SLLI, SRLI and SRAI carry a shift amount in the immediate field
    assign is_shift_imm = dispatch.instr.i_fields.opcode == rv_isa_pkg::OP_IMM &&
                          (dispatch.instr.i_fields.funct3 == rv_isa_pkg::F3_SLL ||
                           dispatch.instr.i_fields.funct3 == rv_isa_pkg::F3_SRL);

    assign dispatch_ready = is_nop || (credit[unit] != '0);
    assign accept         = dispatch_valid && dispatch_ready && !is_nop;

    always_comb begin
        pkt = rs_pkg::wakeup(dispatch, cdb);  // Result landing in the write cycle
        if (dispatch.instr.i_fields.opcode == rv_isa_pkg::OP_IMM) begin
            if (is_shift_imm) begin
                pkt.imm = {27'd0, dispatch.instr.i_fields.imm[4:0]};  // Shamt only
            end else begin
                pkt.imm = {{20{dispatch.instr.i_fields.imm[11]}},
                           dispatch.instr.i_fields.imm};
            end
        end
        if (unit != rv_isa_pkg::UNIT_BR) begin
            pkt.jump       = 1'b0;
            pkt.branch     = 1'b0;
            pkt.pred_taken = 1'b0;
            pkt.btb_hit    = 1'b0;
        end
        if (unit != rv_isa_pkg::UNIT_ADD) begin
            pkt.mem_to_reg = 1'b0;
            pkt.mem_read   = 1'b0;
            pkt.mem_write  = 1'b0;
            pkt.alu_src1   = 1'b0;
            pkt.alu_src2   = 1'b0;
        end
    end

    assign wr_entry.busy = 1'b1;
    assign wr_entry.pkt  = pkt;

    always_comb begin
        wr_en = '0;
        if (accept) begin
            wr_en[unit] = 1'b1;
        end
    end

    // One counter per station, write and return may coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rs_pkg::NUM_UNITS; i++) begin
                credit[i] <= rs_pkg::credit_t'(rs_pkg::RS_DEPTH);
            end
        end else begin
            for (int i = 0; i < rs_pkg::NUM_UNITS; i++) begin
                credit[i] <= credit[i] + rs_pkg::credit_t'(credit_return[i])
                             - rs_pkg::credit_t'(wr_en[i]);
            end
        end
    end

endmodule

// File: logic/reservation_station.sv
module reservation_station (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  rs_pkg::rs_entry_t wr_entry,
    input  rs_pkg::cdb_t      cdb,
    input  logic              grant,
    output logic              req,
    output rs_pkg::rs_entry_t head,
    output logic              credit_return
);

    rs_pkg::rs_entry_t           slots [rs_pkg::RS_DEPTH];
    logic [rs_pkg::RS_DEPTH-1:0] ready;
    rs_pkg::slot_t               free_idx;
    rs_pkg::slot_t               sel;
    logic                        found;
    logic [31:0]                 best_num;

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            ready[i] = slots[i].busy && (&slots[i].pkt.op_valid);
        end
    end

    // Lowest free slot, credits guarantee one exists on a write
    always_comb begin
        free_idx = '0;
        for (int i = rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!slots[i].busy) begin
                free_idx = rs_pkg::slot_t'(i);
            end
        end
    end

    // Oldest ready entry by inst_num
    always_comb begin
        sel      = '0;
        found    = 1'b0;
        best_num = '0;
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (ready[i] && (!found || slots[i].pkt.inst_num < best_num)) begin
                sel      = rs_pkg::slot_t'(i);
                best_num = slots[i].pkt.inst_num;
                found    = 1'b1;
            end
        end
    end

    assign req  = |ready;
    assign head = slots[sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                slots[i].busy <= 1'b0;
            end
            credit_return <= 1'b0;
        end else begin
            credit_return <= grant;  // Slot freed on this edge
            for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
                if (slots[i].busy) begin
                    slots[i].pkt <= rs_pkg::wakeup(slots[i].pkt, cdb);
                end
            end
            if (grant && found) begin
                slots[sel].busy <= 1'b0;
            end
            if (wr_en) begin
                slots[free_idx] <= wr_entry;
            end
        end
    end

endmodule

// File: logic/issue_arbiter.sv
module issue_arbiter (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [rs_pkg::NUM_UNITS-1:0]              req,
    input  rs_pkg::rs_entry_t [rs_pkg::NUM_UNITS-1:0] head,
    input  logic                                      issue_stall,
    output logic [rs_pkg::NUM_UNITS-1:0]              grant,
    output rs_pkg::issue_pkt_t                        issue
);

    rs_pkg::unit_idx_t last_grant;
    rs_pkg::unit_idx_t pick;
    rs_pkg::unit_idx_t idx;
    logic              found;

    // Search starts one past the last winner
    always_comb begin
        grant = '0;
        pick  = last_grant;
        idx   = last_grant;
        found = 1'b0;
        for (int k = 1; k <= rs_pkg::NUM_UNITS; k++) begin
            idx = rs_pkg::unit_idx_t'((int'(last_grant) + k) % rs_pkg::NUM_UNITS);
            if (!found && req[idx] && !issue_stall) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        if (found) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant  <= rs_pkg::unit_idx_t'(rs_pkg::NUM_UNITS - 1);  // Station 0 first
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= found;
            if (found) begin
                last_grant <= pick;
                issue.unit <= rv_isa_pkg::unit_class_t'(pick);
                issue.pkt  <= head[pick].pkt;
            end
        end
    end

endmodule

// File: logic/rs_issue_top.sv
module rs_issue_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rs_pkg::dispatch_pkt_t dispatch,
    input  rs_pkg::cdb_t          cdb,
    input  logic                  issue_stall,
    output logic                  dispatch_ready,
    output rs_pkg::issue_pkt_t    issue
);

    logic [rs_pkg::NUM_UNITS-1:0]              wr_en;
    logic [rs_pkg::NUM_UNITS-1:0]              credit_return;
    logic [rs_pkg::NUM_UNITS-1:0]              req;
    logic [rs_pkg::NUM_UNITS-1:0]              grant;
    rs_pkg::rs_entry_t                         wr_entry;
    rs_pkg::rs_entry_t [rs_pkg::NUM_UNITS-1:0] head;

    dispatch_router dispatch_router_inst (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .credit_return  (credit_return),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .wr_en          (wr_en),
        .wr_entry       (wr_entry)
    );

    // Station i serves unit class i
    generate
        for (genvar i = 0; i < rs_pkg::NUM_UNITS; i++) begin : gen_rs
            reservation_station reservation_station_inst (
                .clk           (clk),
                .reset         (reset),
                .wr_en         (wr_en[i]),
                .wr_entry      (wr_entry),
                .cdb           (cdb),
                .grant         (grant[i]),
                .req           (req[i]),
                .head          (head[i]),
                .credit_return (credit_return[i])
            );
        end
    endgenerate

    issue_arbiter issue_arbiter_inst (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .head        (head),
        .issue_stall (issue_stall),
        .grant       (grant),
        .issue       (issue)
    );

endmodule

// File: test/rs_issue_asserts.sv
module rs_issue_asserts (
    input logic                         clk,
    input logic                         reset,
    input logic [rs_pkg::NUM_UNITS-1:0] wr_en,
    input logic [rs_pkg::NUM_UNITS-1:0] credit_return,
    input logic [rs_pkg::NUM_UNITS-1:0] req,
    input logic [rs_pkg::NUM_UNITS-1:0] grant,
    input rs_pkg::issue_pkt_t           issue
);

    rs_pkg::credit_t held [rs_pkg::NUM_UNITS];  // Entries charged per station

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rs_pkg::NUM_UNITS; i++) begin
                held[i] <= '0;
            end
        end else begin
            for (int i = 0; i < rs_pkg::NUM_UNITS; i++) begin
                held[i] <= held[i] + rs_pkg::credit_t'(wr_en[i])
                           - rs_pkg::credit_t'(credit_return[i]);
            end
        end
    end

    // Only a requesting station may win
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant) && ((grant & ~req) == '0))
        else $error("grant is not one-hot or zero, or idle station granted: %b", grant);

    issue_operands: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> &issue.pkt.op_valid)
        else $error("issue with an operand still waiting");

    // Credit = RS_DEPTH - held
    generate
        for (genvar i = 0; i < rs_pkg::NUM_UNITS; i++) begin : gen_credit
            no_underflow: assert property (@(posedge clk) disable iff (reset)
                wr_en[i] && !credit_return[i] |->
                    held[i] < rs_pkg::credit_t'(rs_pkg::RS_DEPTH))
                else $error("station %0d credit counter below zero", i);
            no_overflow: assert property (@(posedge clk) disable iff (reset)
                credit_return[i] && !wr_en[i] |-> held[i] != '0)
                else $error("station %0d credit counter above RS_DEPTH", i);
        end
    endgenerate

endmodule

bind rs_issue_top rs_issue_asserts rs_issue_asserts_inst (
    .clk           (clk),
    .reset         (reset),
    .wr_en         (wr_en),
    .credit_return (credit_return),
    .req           (req),
    .grant         (grant),
    .issue         (issue)
);

// File: test/rs_issue_tb.sv
module rs_issue_tb;

    typedef struct packed {
        logic [31:0] instr;
        logic [1:0]  op_valid;  // 01 waits for op2 on the cdb
        logic        exp_issue;
        logic [1:0]  exp_unit;
        logic [4:0]  exp_mem;   // mem_to_reg mem_read mem_write alu_src1 alu_src2
        logic [3:0]  exp_br;    // jump branch pred_taken btb_hit
        logic [31:0] exp_imm;   // Passes through unless OP-IMM
    } row_t;

    localparam int NUM_ROWS = 13;
    localparam int TIMEOUT  = 50;

    localparam logic [31:0] PKT_IMM   = 32'h87654321;

    localparam logic [31:0] ADD_WORD  = 32'h002081B3;
    localparam logic [31:0] SUB_WORD  = 32'h402081B3;
    localparam logic [31:0] LW_WORD   = 32'h0000A183;
    localparam logic [31:0] ADDI_WORD = 32'hFFC08193;  // Immediate -4
    localparam logic [31:0] SRAI_WORD = 32'h4050D193;  // Shift by 5
    localparam logic [31:0] MUL_WORD  = 32'h022081B3;
    localparam logic [31:0] DIV_WORD  = 32'h0220C1B3;
    localparam logic [31:0] REM_WORD  = 32'h0220E1B3;
    localparam logic [31:0] JAL_WORD  = 32'h000000EF;
    localparam logic [31:0] JALR_WORD = 32'h00008067;
    localparam logic [31:0] BEQ_WORD  = 32'h00208063;
    localparam logic [31:0] NOP_WORD  = 32'h00000000;

    logic                  clk;
    logic                  reset;
    logic                  dispatch_valid;
    rs_pkg::dispatch_pkt_t dispatch;
    rs_pkg::cdb_t          cdb;
    logic                  issue_stall;
    logic                  dispatch_ready;
    rs_pkg::issue_pkt_t    issue;

    rs_pkg::issue_pkt_t issued [$];
    integer             seed;
    int                 next_num;
    int                 errors;
    int                 checks;
    int                 tests;
    logic [1:0]         last_unit;

    row_t rows [NUM_ROWS] = '{
        '{ADD_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, PKT_IMM},
        '{SUB_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, PKT_IMM},
        '{LW_WORD,   2'b11, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, PKT_IMM},
        '{ADDI_WORD, 2'b11, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, 32'hfffffffc},
        '{SRAI_WORD, 2'b11, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, 32'h00000005},
        '{MUL_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_MUL, 5'h00, 4'h0, PKT_IMM},
        '{DIV_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_DIV, 5'h00, 4'h0, PKT_IMM},
        '{REM_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_DIV, 5'h00, 4'h0, PKT_IMM},
        '{JAL_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_BR,  5'h00, 4'hf, PKT_IMM},
        '{JALR_WORD, 2'b11, 1'b1, rv_isa_pkg::UNIT_BR,  5'h00, 4'hf, PKT_IMM},
        '{BEQ_WORD,  2'b11, 1'b1, rv_isa_pkg::UNIT_BR,  5'h00, 4'hf, PKT_IMM},
        '{NOP_WORD,  2'b11, 1'b0, rv_isa_pkg::UNIT_ADD, 5'h00, 4'h0, PKT_IMM},
        '{ADD_WORD,  2'b01, 1'b1, rv_isa_pkg::UNIT_ADD, 5'h1f, 4'h0, PKT_IMM}
    };

    rs_issue_top rs_issue_top_inst (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .issue_stall    (issue_stall),
        .dispatch_ready (dispatch_ready),
        .issue          (issue)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (!reset && issue.valid) begin
            issued.push_back(issue);
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Control bits all set, every class clears its own subset
    function automatic rs_pkg::dispatch_pkt_t make_pkt(input logic [31:0] word,
                                                      input logic [1:0] valid_bits);
        rs_pkg::dispatch_pkt_t p;
        p          = '0;
        p.instr    = word;
        p.op1      = $random(seed);
        p.op2      = $random(seed);
        p.pc       = $random(seed);
        p.imm      = PKT_IMM;
        p.op1_phy  = 8'h11;
        p.op2_phy  = 8'h21;
        p.rd_phy   = 8'h31;
        p.op_valid = valid_bits;
        p.inst_num = 32'(next_num);
        p.alu_op   = 4'(next_num);
        {p.mem_to_reg, p.mem_read, p.mem_write, p.alu_src1, p.alu_src2} = 5'h1f;
        {p.jump, p.branch, p.pred_taken, p.btb_hit} = 4'hf;
        next_num++;
        return p;
    endfunction

    task automatic send_pkt(input rs_pkg::dispatch_pkt_t p);
        int n;
        n = 0;
        @(negedge clk);
        dispatch       = p;
        dispatch_valid = 1'b1;
        #1;
        while (!dispatch_ready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!dispatch_ready) begin
            $display("Timeout: dispatch_ready stayed low for %0d cycles", TIMEOUT);
            errors++;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_ready(input rs_pkg::dispatch_pkt_t p);
        int n;
        n        = 0;
        dispatch = p;
        #1;
        while (!dispatch_ready && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!dispatch_ready) begin
            $display("Timeout: dispatch_ready did not return within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic wait_issue(output rs_pkg::issue_pkt_t got, output logic found);
        int n;
        n     = 0;
        found = 1'b0;
        got   = '0;
        while (!found && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            if (issued.size() != 0) begin
                got   = issued.pop_front();
                found = 1'b1;
            end
            n++;
        end
        if (!found) begin
            $display("Timeout: no instruction issued within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic broadcast(input logic [7:0] tag, input logic [31:0] value);
        @(negedge clk);
        cdb.valid = 1'b1;
        cdb.tag   = tag;
        cdb.value = value;
        @(negedge clk);
        cdb.valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("%-32s %s", name, (errors == start) ? "ok" : "failed");
    endtask

    initial begin
        rs_pkg::dispatch_pkt_t pkt;
        rs_pkg::issue_pkt_t    got;
        logic                  found;
        logic [31:0]           exp_op2;
        logic [1:0]            next_unit;
        int                    start;
        int                    base;

        seed           = 32'hd58c;
        next_num       = 1;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        last_unit      = 2'd0;
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        issue_stall    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            start   = errors;
            pkt     = make_pkt(rows[r].instr, rows[r].op_valid);
            exp_op2 = pkt.op2;
            send_pkt(pkt);
            if (!rows[r].op_valid[1]) begin
                idle(5);
                check(32'(issued.size()), 0, "issue before op2 wakeup");
                broadcast(pkt.op2_phy ^ 8'h80, ~exp_op2);  // Wrong tag
                idle(5);
                check(32'(issued.size()), 0, "issue after wrong-tag broadcast");
                exp_op2 = $random(seed);
                broadcast(pkt.op2_phy, exp_op2);
            end
            if (rows[r].exp_issue) begin
                wait_issue(got, found);
                if (found) begin
                    check(32'(got.unit), 32'(rows[r].exp_unit), "unit");
                    check(got.pkt.instr, pkt.instr, "instr");
                    check(got.pkt.op1, pkt.op1, "op1");
                    check(got.pkt.op2, exp_op2, "op2");
                    check(32'(got.pkt.op_valid), 32'(2'b11), "operand valid bits");
                    check(32'(got.pkt.rd_phy), 32'(pkt.rd_phy), "rd_phy");
                    check(got.pkt.imm, rows[r].exp_imm, "imm");
                    check(got.pkt.pc, pkt.pc, "pc");
                    check(32'(got.pkt.alu_op), 32'(pkt.alu_op), "alu_op");
                    check(got.pkt.inst_num, pkt.inst_num, "inst_num");
                    check(32'({got.pkt.mem_to_reg, got.pkt.mem_read, got.pkt.mem_write,
                               got.pkt.alu_src1, got.pkt.alu_src2}),
                          32'(rows[r].exp_mem), "memory bits");
                    check(32'({got.pkt.jump, got.pkt.branch, got.pkt.pred_taken,
                               got.pkt.btb_hit}),
                          32'(rows[r].exp_br), "branch bits");
                end
            end else begin
                idle(10);
                check(32'(issued.size()), 0, "dropped instruction issued");
            end
            report_test($sformatf("Row %0d instr %h", r, rows[r].instr), start);
        end

        // Fill the multiply station in reverse program order
        start       = errors;
        issue_stall = 1'b1;
        base        = next_num;
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            pkt          = make_pkt(MUL_WORD, 2'b11);
            pkt.inst_num = 32'(base + rs_pkg::RS_DEPTH - 1 - k);
            send_pkt(pkt);
        end
        dispatch = make_pkt(MUL_WORD, 2'b11);
        #1;
        check(32'(dispatch_ready), 0, "ready for mul with station full");
        dispatch = make_pkt(ADD_WORD, 2'b11);
        #1;
        check(32'(dispatch_ready), 1, "ready for add with mul station full");
        @(negedge clk);
        issue_stall = 1'b0;
        for (int k = 0; k < rs_pkg::RS_DEPTH; k++) begin
            wait_issue(got, found);
            if (found) begin
                check(32'(got.unit), 32'(rv_isa_pkg::UNIT_MUL), "back-pressure unit");
                check(got.pkt.inst_num, 32'(base + k), "issue order by inst_num");
            end
        end
        last_unit = rv_isa_pkg::UNIT_MUL;
        wait_ready(make_pkt(MUL_WORD, 2'b11));
        report_test("Credit back-pressure and order", start);

        // One ready entry per station, released together
        start       = errors;
        issue_stall = 1'b1;
        send_pkt(make_pkt(BEQ_WORD, 2'b11));
        send_pkt(make_pkt(DIV_WORD, 2'b11));
        send_pkt(make_pkt(ADD_WORD, 2'b11));
        send_pkt(make_pkt(MUL_WORD, 2'b11));
        @(negedge clk);
        issue_stall = 1'b0;
        for (int k = 0; k < rs_pkg::NUM_UNITS; k++) begin
            next_unit = last_unit + 2'd1;
            wait_issue(got, found);
            if (found) begin
                check(32'(got.unit), 32'(next_unit), "round-robin unit");
            end
            last_unit = next_unit;
        end
        report_test("Round-robin across stations", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
logic/rv_isa_pkg.sv
logic/rs_pkg.sv
logic/dispatch_router.sv
logic/reservation_station.sv
logic/issue_arbiter.sv
logic/rs_issue_top.sv
test/rs_issue_asserts.sv
test/rs_issue_tb.sv

// File: build.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module rs_issue_tb -o rs_issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/rs_issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
